// ==== hdl/rvPkg.sv ====
package rvPkg;

	// **************************************************
	// Widths and basic types
	localparam int xlen = 32;

	typedef logic [4:0]      regAddrT;
	typedef logic [xlen-1:0] wordT;

	// addi x0,x0,0
	localparam wordT nopWord = 32'h0000_0013;

	// **************************************************
	// RV32I major opcodes
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	// ALU operations, aluPassB serves lui
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	// Forwarding sources, register file value first
	typedef enum logic [1:0] {fwdReg, fwdEx, fwdMem, fwdWb} fwdSelT;

	// Operand B source
	typedef enum logic [1:0] {bSelReg, bSelImm, bSelFour} bSelT;

	// **************************************************
	// Pipeline payloads
	typedef struct packed {
		wordT pc;
		wordT pcPlus4;
		wordT instr;
	} ifIdT;

	typedef struct packed {
		wordT    pc;
		wordT    opA;
		wordT    opB;
		wordT    imm;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		aluOpT   aluOp;
		logic    aSelPc;
		bSelT    bSel;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
	} idExT;

	typedef struct packed {
		wordT    aluResult;
		wordT    storeData;
		regAddrT rd;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
	} exMemT;

	typedef struct packed {
		wordT    loadData;
		wordT    aluResult;
		regAddrT rd;
		logic    regWrite;
		logic    memToReg;
	} memWbT;

	// Forwarding mux shared by decode and execute
	function automatic wordT pickFwd(input fwdSelT sel, input wordT regVal,
		input wordT exVal, input wordT memVal, input wordT wbVal);
		case (sel)
			fwdEx:   return exVal;
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

// ==== hdl/pipeRegister.sv ====
module pipeRegister #(
	parameter type payloadT = logic [31:0]
)
(
	input  logic    iCLK,
	input  logic    iRST,
	input  logic    hold,
	input  logic    clear,
	input  payloadT d,
	output payloadT q
);

	// Clear wins over hold, hold keeps the old payload
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			q <= '0;
		else if (clear)
			q <= '0;
		else if (!hold)
			q <= d;
	end

endmodule

// ==== hdl/regFile.sv ====
module regFile
	import rvPkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  regAddrT rs1,
	input  regAddrT rs2,
	input  regAddrT rd,
	input  wordT    wdata,
	input  logic    we,
	output wordT    rdata1,
	output wordT    rdata2
);

	wordT regs [32];

	// Write port, x0 never written
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && rd != '0)
		begin
			regs[rd] <= wdata;
		end
	end

	// Read ports, x0 hardwired to zero
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/fetchStage.sv ====
module fetchStage
	import rvPkg::*;
#(
	parameter wordT resetPc = '0
)
(
	input  logic iCLK,
	input  logic iRST,
	input  logic stall,
	input  logic redirect,
	input  wordT redirectPc,
	input  wordT instrData,
	output wordT instrAddr,
	output ifIdT ifId
);

	wordT pc;
	wordT pcPlus4;
	ifIdT ifIdNext;

	assign pcPlus4   = pc + 32'd4;
	assign instrAddr = pc;

	// Redirect first, then sequential fetch unless stalled
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			pc <= resetPc;
		else if (redirect)
			pc <= redirectPc;
		else if (!stall)
			pc <= pcPlus4;
	end

	// Squash the wrong-path word with a NOP
	assign ifIdNext.pc      = pc;
	assign ifIdNext.pcPlus4 = pcPlus4;
	assign ifIdNext.instr   = redirect ? nopWord : instrData;

	pipeRegister #(.payloadT(ifIdT)) ifIdReg0 (
		.iCLK (iCLK),
		.iRST (iRST),
		.hold (stall),
		.clear(1'b0),
		.d    (ifIdNext),
		.q    (ifId)
	);

endmodule

// ==== hdl/decodeStage.sv ====
module decodeStage
	import rvPkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  ifIdT    ifId,
	input  logic    stall,
	input  fwdSelT  fwdIdA,
	input  fwdSelT  fwdIdB,
	input  wordT    exResult,
	input  wordT    memResult,
	input  wordT    wbValue,
	input  regAddrT wbRd,
	input  logic    wbWe,
	output regAddrT rs1,
	output regAddrT rs2,
	output regAddrT rd,
	output logic    usesRs1,
	output logic    usesRs2,
	output logic    resolvesEarly,
	output logic    redirect,
	output wordT    redirectPc,
	output idExT    idEx
);

	wordT       instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7b5;
	wordT       immI, immS, immB, immU, immJ, imm;
	aluOpT      f3Op, aluOp;
	bSelT       bSel;
	logic       aSelPc, memRead, memWrite, regWrite;
	logic       isBranch, isJal, isJalr, condTrue;
	wordT       readA, readB, valA, valB, jalrSum;
	idExT       idExNext;

	// **************************************************
	// Instruction fields
	assign instr    = ifId.instr;
	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7b5 = instr[30];
	assign rs1      = instr[19:15];
	assign rs2      = instr[24:20];
	assign rd       = instr[11:7];

	// Immediate of each format
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3 to ALU op, sub only for register form
	always_comb
	begin
		case (funct3)
			3'b000: f3Op = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
			3'b001: f3Op = aluSll;
			3'b010: f3Op = aluSlt;
			3'b011: f3Op = aluSltu;
			3'b100: f3Op = aluXor;
			3'b101: f3Op = funct7b5 ? aluSra : aluSrl;
			3'b110: f3Op = aluOr;
			default: f3Op = aluAnd;
		endcase
	end

	// **************************************************
	// Main decoder, unknown opcodes fall through as NOP
	always_comb
	begin
		aluOp    = aluAdd;
		aSelPc   = 1'b0;
		bSel     = bSelReg;
		memRead  = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		usesRs1  = 1'b0;
		usesRs2  = 1'b0;
		isBranch = 1'b0;
		isJal    = 1'b0;
		isJalr   = 1'b0;
		imm      = immI;
		case (opcode)
			opLui:
			begin
				regWrite = 1'b1;
				aluOp    = aluPassB;
				bSel     = bSelImm;
				imm      = immU;
			end
			opAuipc:
			begin
				regWrite = 1'b1;
				aSelPc   = 1'b1;
				bSel     = bSelImm;
				imm      = immU;
			end
			opJal:
			begin
				// Link PC+4 formed by the ALU
				regWrite = 1'b1;
				aSelPc   = 1'b1;
				bSel     = bSelFour;
				isJal    = 1'b1;
				imm      = immJ;
			end
			opJalr:
			begin
				regWrite = 1'b1;
				aSelPc   = 1'b1;
				bSel     = bSelFour;
				isJalr   = 1'b1;
				usesRs1  = 1'b1;
			end
			opBranch:
			begin
				isBranch = 1'b1;
				usesRs1  = 1'b1;
				usesRs2  = 1'b1;
				imm      = immB;
			end
			opLoad:
			begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				usesRs1  = 1'b1;
				bSel     = bSelImm;
			end
			opStore:
			begin
				memWrite = 1'b1;
				usesRs1  = 1'b1;
				usesRs2  = 1'b1;
				bSel     = bSelImm;
				imm      = immS;
			end
			opImm:
			begin
				regWrite = 1'b1;
				usesRs1  = 1'b1;
				bSel     = bSelImm;
				aluOp    = f3Op;
			end
			opReg:
			begin
				regWrite = 1'b1;
				usesRs1  = 1'b1;
				usesRs2  = 1'b1;
				aluOp    = f3Op;
			end
			default:
			begin
				regWrite = 1'b0;
			end
		endcase
	end

	// Register file, write comes from writeback
	regFile regFile0 (
		.iCLK  (iCLK),
		.iRST  (iRST),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd    (wbRd),
		.wdata (wbValue),
		.we    (wbWe),
		.rdata1(readA),
		.rdata2(readB)
	);

	// Decode forwarding
	assign valA = pickFwd(fwdIdA, readA, exResult, memResult, wbValue);
	assign valB = pickFwd(fwdIdB, readB, exResult, memResult, wbValue);

	// **************************************************
	// Branch resolution
	always_comb
	begin
		case (funct3)
			3'b000: condTrue = (valA == valB);
			3'b001: condTrue = (valA != valB);
			3'b100: condTrue = ($signed(valA) < $signed(valB));
			3'b101: condTrue = ($signed(valA) >= $signed(valB));
			3'b110: condTrue = (valA < valB);
			3'b111: condTrue = (valA >= valB);
			default: condTrue = 1'b0;
		endcase
	end

	// jalr target with bit 0 cleared
	assign jalrSum       = valA + imm;
	assign resolvesEarly = isBranch | isJalr;
	assign redirect      = (isJal | isJalr | (isBranch & condTrue)) & ~stall;
	assign redirectPc    = isJalr ? {jalrSum[xlen-1:1], 1'b0} : ifId.pc + imm;

	// ID/EX payload, stall turns it into a bubble
	assign idExNext.pc       = ifId.pc;
	assign idExNext.opA      = valA;
	assign idExNext.opB      = valB;
	assign idExNext.imm      = imm;
	assign idExNext.rs1      = rs1;
	assign idExNext.rs2      = rs2;
	assign idExNext.rd       = rd;
	assign idExNext.aluOp    = aluOp;
	assign idExNext.aSelPc   = aSelPc;
	assign idExNext.bSel     = bSel;
	assign idExNext.memRead  = memRead;
	assign idExNext.memWrite = memWrite;
	assign idExNext.regWrite = regWrite;

	pipeRegister #(.payloadT(idExT)) idExReg0 (
		.iCLK (iCLK),
		.iRST (iRST),
		.hold (1'b0),
		.clear(stall),
		.d    (idExNext),
		.q    (idEx)
	);

endmodule

// ==== hdl/hazardUnit.sv ====
module hazardUnit
	import rvPkg::*;
(
	input  regAddrT rs1,
	input  regAddrT rs2,
	input  logic    usesRs1,
	input  logic    usesRs2,
	input  logic    resolvesEarly,
	input  regAddrT exRs1,
	input  regAddrT exRs2,
	input  regAddrT exRd,
	input  regAddrT memRd,
	input  regAddrT wbRd,
	input  logic    exRegWrite,
	input  logic    exMemRead,
	input  logic    memRegWrite,
	input  logic    memMemRead,
	input  logic    wbRegWrite,
	output logic    stall,
	output fwdSelT  fwdIdA,
	output fwdSelT  fwdIdB,
	output fwdSelT  fwdExA,
	output fwdSelT  fwdExB
);

	// Decode sources, youngest producer first
	function automatic fwdSelT selectId(input regAddrT src);
		if (src == '0)
			return fwdReg;
		else if (exRegWrite && exRd == src)
			return fwdEx;
		else if (memRegWrite && memRd == src)
			return fwdMem;
		else if (wbRegWrite && wbRd == src)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	// Execute sources, memory before writeback
	function automatic fwdSelT selectEx(input regAddrT src);
		if (src == '0)
			return fwdReg;
		else if (memRegWrite && memRd == src)
			return fwdMem;
		else if (wbRegWrite && wbRd == src)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	// Load producer feeding a live decode source
	function automatic logic loadHit(input regAddrT prodRd, input logic isLoad);
		return isLoad && prodRd != '0 &&
			((usesRs1 && prodRd == rs1) || (usesRs2 && prodRd == rs2));
	endfunction

	always_comb
	begin
		fwdIdA = selectId(rs1);
		fwdIdB = selectId(rs2);
		fwdExA = selectEx(exRs1);
		fwdExB = selectEx(exRs2);
		// Early resolvers also wait out a load in memory
		stall  = loadHit(exRd, exMemRead) | (resolvesEarly & loadHit(memRd, memMemRead));
	end

endmodule

// ==== hdl/executeStage.sv ====
module executeStage
	import rvPkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  idExT    idEx,
	input  fwdSelT  fwdExA,
	input  fwdSelT  fwdExB,
	input  wordT    memResult,
	input  wordT    wbValue,
	output regAddrT exRs1,
	output regAddrT exRs2,
	output regAddrT exRd,
	output logic    exRegWrite,
	output logic    exMemRead,
	output wordT    exResult,
	output exMemT   exMem
);

	wordT  fwdA, fwdB, aluA, aluB, aluResult;
	exMemT exMemNext;

	// Execute forwarding, never from its own stage
	assign fwdA = (fwdExA == fwdMem) ? memResult :
		(fwdExA == fwdWb) ? wbValue : idEx.opA;
	assign fwdB = (fwdExB == fwdMem) ? memResult :
		(fwdExB == fwdWb) ? wbValue : idEx.opB;

	// Operand selection
	assign aluA = idEx.aSelPc ? idEx.pc : fwdA;

	always_comb
	begin
		case (idEx.bSel)
			bSelImm:  aluB = idEx.imm;
			bSelFour: aluB = 32'd4;
			default:  aluB = fwdB;
		endcase
	end

	// ALU
	always_comb
	begin
		case (idEx.aluOp)
			aluAdd:   aluResult = aluA + aluB;
			aluSub:   aluResult = aluA - aluB;
			aluSll:   aluResult = aluA << aluB[4:0];
			aluSlt:   aluResult = {{(xlen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			aluSltu:  aluResult = {{(xlen-1){1'b0}}, aluA < aluB};
			aluXor:   aluResult = aluA ^ aluB;
			aluSrl:   aluResult = aluA >> aluB[4:0];
			aluSra:   aluResult = $signed(aluA) >>> aluB[4:0];
			aluOr:    aluResult = aluA | aluB;
			aluAnd:   aluResult = aluA & aluB;
			aluPassB: aluResult = aluB;
			default:  aluResult = '0;
		endcase
	end

	// Hazard view of this stage
	assign exRs1      = idEx.rs1;
	assign exRs2      = idEx.rs2;
	assign exRd       = idEx.rd;
	assign exRegWrite = idEx.regWrite;
	assign exMemRead  = idEx.memRead;
	assign exResult   = aluResult;

	// Forwarded rs2 is the store data
	assign exMemNext.aluResult = aluResult;
	assign exMemNext.storeData = fwdB;
	assign exMemNext.rd        = idEx.rd;
	assign exMemNext.memRead   = idEx.memRead;
	assign exMemNext.memWrite  = idEx.memWrite;
	assign exMemNext.regWrite  = idEx.regWrite;

	pipeRegister #(.payloadT(exMemT)) exMemReg0 (
		.iCLK (iCLK),
		.iRST (iRST),
		.hold (1'b0),
		.clear(1'b0),
		.d    (exMemNext),
		.q    (exMem)
	);

endmodule

// ==== hdl/memWriteback.sv ====
module memWriteback
	import rvPkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  exMemT   exMem,
	input  wordT    dataRdata,
	output logic    dataRead,
	output logic    dataWrite,
	output wordT    dataAddr,
	output wordT    dataWdata,
	output regAddrT memRd,
	output logic    memRegWrite,
	output logic    memMemRead,
	output wordT    memResult,
	output regAddrT wbRd,
	output logic    wbWe,
	output wordT    wbValue
);

	memWbT memWbNext;
	memWbT memWb;

	// Data bus straight from EX/MEM
	assign dataRead  = exMem.memRead;
	assign dataWrite = exMem.memWrite;
	assign dataAddr  = exMem.aluResult;
	assign dataWdata = exMem.storeData;

	// Hazard view of memory stage
	assign memRd       = exMem.rd;
	assign memRegWrite = exMem.regWrite;
	assign memMemRead  = exMem.memRead;
	assign memResult   = exMem.aluResult;

	// Load data captured with the ALU result
	assign memWbNext.loadData  = dataRdata;
	assign memWbNext.aluResult = exMem.aluResult;
	assign memWbNext.rd        = exMem.rd;
	assign memWbNext.regWrite  = exMem.regWrite;
	assign memWbNext.memToReg  = exMem.memRead;

	pipeRegister #(.payloadT(memWbT)) memWbReg0 (
		.iCLK (iCLK),
		.iRST (iRST),
		.hold (1'b0),
		.clear(1'b0),
		.d    (memWbNext),
		.q    (memWb)
	);

	// Writeback select
	assign wbRd    = memWb.rd;
	assign wbWe    = memWb.regWrite;
	assign wbValue = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

// ==== hdl/riscvPipeline.sv ====
module riscvPipeline
	import rvPkg::*;
#(
	parameter wordT resetPc = '0
)
(
	input  logic iCLK,
	input  logic iRST,
	output wordT instrAddr,
	input  wordT instrData,
	output logic dataRead,
	output logic dataWrite,
	output wordT dataAddr,
	output wordT dataWdata,
	input  wordT dataRdata
);

	// **************************************************
	// Stage payloads and cross-stage wires
	ifIdT    ifId;
	idExT    idEx;
	exMemT   exMem;
	logic    stall, redirect;
	wordT    redirectPc;
	fwdSelT  fwdIdA, fwdIdB, fwdExA, fwdExB;
	regAddrT idRs1, idRs2, exRs1, exRs2, exRd, memRd, wbRd;
	logic    usesRs1, usesRs2, resolvesEarly;
	logic    exRegWrite, exMemRead, memRegWrite, memMemRead, wbWe;
	wordT    exResult, memResult, wbValue;

	fetchStage #(.resetPc(resetPc)) fetch0 (
		.iCLK(iCLK), .iRST(iRST), .stall(stall), .redirect(redirect),
		.redirectPc(redirectPc), .instrData(instrData), .instrAddr(instrAddr), .ifId(ifId)
	);

	// Decode's own rd is carried through ID/EX
	decodeStage decode0 (
		.iCLK(iCLK), .iRST(iRST), .ifId(ifId), .stall(stall),
		.fwdIdA(fwdIdA), .fwdIdB(fwdIdB), .exResult(exResult), .memResult(memResult),
		.wbValue(wbValue), .wbRd(wbRd), .wbWe(wbWe), .rs1(idRs1), .rs2(idRs2), .rd(),
		.usesRs1(usesRs1), .usesRs2(usesRs2), .resolvesEarly(resolvesEarly),
		.redirect(redirect), .redirectPc(redirectPc), .idEx(idEx)
	);

	hazardUnit hazard0 (
		.rs1(idRs1), .rs2(idRs2), .usesRs1(usesRs1), .usesRs2(usesRs2),
		.resolvesEarly(resolvesEarly), .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
		.memRd(memRd), .wbRd(wbRd), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.memRegWrite(memRegWrite), .memMemRead(memMemRead), .wbRegWrite(wbWe),
		.stall(stall), .fwdIdA(fwdIdA), .fwdIdB(fwdIdB), .fwdExA(fwdExA), .fwdExB(fwdExB)
	);

	executeStage execute0 (
		.iCLK(iCLK), .iRST(iRST), .idEx(idEx), .fwdExA(fwdExA), .fwdExB(fwdExB),
		.memResult(memResult), .wbValue(wbValue), .exRs1(exRs1), .exRs2(exRs2),
		.exRd(exRd), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.exResult(exResult), .exMem(exMem)
	);

	// Memory access and writeback
	memWriteback memWb0 (
		.iCLK(iCLK), .iRST(iRST), .exMem(exMem), .dataRdata(dataRdata),
		.dataRead(dataRead), .dataWrite(dataWrite), .dataAddr(dataAddr),
		.dataWdata(dataWdata), .memRd(memRd), .memRegWrite(memRegWrite),
		.memMemRead(memMemRead), .memResult(memResult), .wbRd(wbRd), .wbWe(wbWe),
		.wbValue(wbValue)
	);

endmodule

// ==== test/riscvPipelineAssertions.sv ====
module riscvPipelineAssertions
	import rvPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input wordT instrAddr,
	input logic dataRead,
	input logic dataWrite,
	input wordT dataAddr
);

	// **************************************************
	// Data bus strobes never overlap
	strobeExclusive: assert property (@(posedge iCLK) disable iff (iRST)
		!(dataRead && dataWrite))
		else $error("dataRead and dataWrite high in the same cycle");

	// Word access only
	dataAligned: assert property (@(posedge iCLK) disable iff (iRST)
		(dataRead || dataWrite) |-> (dataAddr[1:0] == 2'b00))
		else $error("dataAddr not word aligned during an access");

	// Fetch address always on a word
	instrAligned: assert property (@(posedge iCLK) instrAddr[1:0] == 2'b00)
		else $error("instrAddr not word aligned");

	// Bus idle while reset is held
	resetIdle: assert property (@(posedge iCLK) iRST |-> (!dataRead && !dataWrite))
		else $error("data strobe high during reset");

endmodule

// ==== test/riscvPipelineTb.sv ====
module riscvPipelineTb
	import rvPkg::*;
();

	// **************************************************
	// Run limits and memory size
	localparam int storeTimeout = 200;
	localparam int quietCycles  = 50;
	localparam int memWords     = 256;

	logic iCLK;
	logic iRST;
	wordT instrAddr;
	wordT instrData;
	logic dataRead;
	logic dataWrite;
	wordT dataAddr;
	wordT dataWdata;
	wordT dataRdata;

	// Word-indexed memories, data image copied in during reset
	wordT instrMem [memWords];
	wordT dataMem  [memWords];
	wordT dataInit [memWords];

	// Expected stores in program order
	wordT expAddr [$];
	wordT expData [$];

	riscvPipeline #(.resetPc(32'h0000_0000)) dut0 (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dataRead (dataRead),
		.dataWrite(dataWrite),
		.dataAddr (dataAddr),
		.dataWdata(dataWdata),
		.dataRdata(dataRdata)
	);

	// Bus protocol checks inside the DUT
	bind riscvPipeline riscvPipelineAssertions assertions0 (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.instrAddr(instrAddr),
		.dataRead (dataRead),
		.dataWrite(dataWrite),
		.dataAddr (dataAddr)
	);

	// Clock, period 4
	initial
	begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	// Both memories answer in the same cycle
	assign instrData = instrMem[instrAddr[9:2]];
	// Data only while the load strobe is up
	assign dataRdata = dataRead ? dataMem[dataAddr[9:2]] : '0;

	// Preload during reset, stores land at the rising edge
	always @(posedge iCLK)
	begin
		if (iRST)
			dataMem <= dataInit;
		else if (dataWrite)
			dataMem[dataAddr[9:2]] <= dataWdata;
	end

	// **************************************************
	// Vector file loader
	task automatic loadVectors();
		int               fd;
		int               fields;
		logic             done;
		logic [7:0]       kind;
		wordT             vecAddr;
		wordT             vecWord;
		wordT             byteAddr;
		logic [8*128-1:0] skipped;
		// Unloaded words carry their own address
		for (int i = 0; i < memWords; i++)
		begin
			byteAddr    = wordT'(i) << 2;
			// Opcode zero, runs as a NOP
			instrMem[i] = {byteAddr[24:0], 7'b0000000};
			dataInit[i] = byteAddr ^ 32'hDA7A_0000;
		end
		fd = $fopen("test/programVectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/programVectors.txt for reading");
			stopWithFailure();
		end
		done = 1'b0;
		while (!done)
		begin
			fields = $fscanf(fd, " %c", kind);
			if (fields != 1)
				done = 1'b1;
			else if (kind == "#")
				fields = $fgets(skipped, fd);
			else
			begin
				fields = $fscanf(fd, "%h %h", vecAddr, vecWord);
				if (fields != 2)
				begin
					$display("vector line of kind %c lacks an address or a word", kind);
					stopWithFailure();
				end
				case (kind)
					"I": instrMem[vecAddr[9:2]] = vecWord;
					"D": dataInit[vecAddr[9:2]] = vecWord;
					"S":
					begin
						expAddr.push_back(vecAddr);
						expData.push_back(vecWord);
					end
					default:
					begin
						$display("vector file holds a line of unknown kind %c", kind);
						stopWithFailure();
					end
				endcase
			end
		end
		$fclose(fd);
		if (expAddr.size() == 0)
		begin
			$display("vector file lists no expected stores");
			stopWithFailure();
		end
	endtask

	// **************************************************
	// Store checker
	task automatic waitForStore(input int index);
		int cycles;
		cycles = 0;
		// Step past the previous store cycle
		@(negedge iCLK);
		while (!dataWrite && cycles < storeTimeout)
		begin
			@(negedge iCLK);
			cycles++;
		end
		if (!dataWrite)
		begin
			$display("expected store %0d to %h never appeared on the data bus",
				index, expAddr[index]);
			stopWithFailure();
		end
	endtask

	task automatic checkStore(input int index);
		assert (dataAddr == expAddr[index])
		else
		begin
			$display("error: time %0t dataAddr got %h expected %h",
				$time, dataAddr, expAddr[index]);
			stopWithFailure();
		end
		assert (dataWdata == expData[index])
		else
		begin
			$display("error: time %0t dataWdata got %h expected %h",
				$time, dataWdata, expData[index]);
			stopWithFailure();
		end
	endtask

	// Self loop at the end, bus must stay silent
	task automatic checkQuiet();
		for (int c = 0; c < quietCycles; c++)
		begin
			@(negedge iCLK);
			assert (!dataWrite)
			else
			begin
				$display("time %0t extra write to %h after the last expected store",
					$time, dataAddr);
				stopWithFailure();
			end
		end
	endtask

	task automatic stopWithFailure();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	// **************************************************
	// Main sequence
	initial
	begin
		iRST = 1'b1;
		loadVectors();
		// Reset for 8 rising edges
		repeat (8) @(posedge iCLK);
		iRST <= 1'b0;
		for (int n = 0; n < expAddr.size(); n++)
		begin
			waitForStore(n);
			checkStore(n);
		end
		checkQuiet();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== test/programVectors.txt ====
# Line kind then byte address then word in hex
# I program word  D preloaded data word  S expected store in program order
# ALU chain with forwarding
I 00000000 30000093
I 00000004 FFB00113
I 00000008 00700193
I 0000000C 00310233
I 00000010 0040A023
I 00000014 402182B3
I 00000018 0050A223
I 0000001C 00312333
I 00000020 003133B3
I 00000024 0060A423
I 00000028 0070A623
I 0000002C 800014B7
I 00000030 4044D513
I 00000034 0034D5B3
I 00000038 00919613
I 0000003C 00A0A823
I 00000040 00B0AA23
I 00000044 00C0AC23
I 00000048 00001697
I 0000004C 0FF6C713
I 00000050 002777B3
I 00000054 7007E813
I 00000058 0100AE23
# Loads with an immediate use
I 0000005C 0000A883
I 00000060 06488913
I 00000064 0320A023
I 00000068 0800A983
# Six branch conditions both ways and skipped stores
I 0000006C 01198463
I 00000070 0310A223
I 00000074 01199463
I 00000078 0530A023
I 0000007C 00314463
I 00000080 0530A023
I 00000084 00315463
I 00000088 0230A423
I 0000008C 00316463
I 00000090 0220A623
I 00000094 00317463
I 00000098 0530A023
I 0000009C 00318463
I 000000A0 0530A023
I 000000A4 00319463
I 000000A8 02C0A823
I 000000AC 0021C463
I 000000B0 0250AA23
I 000000B4 0021D463
I 000000B8 0530A023
I 000000BC 0021E463
I 000000C0 0530A023
I 000000C4 0021F463
I 000000C8 02A0AC23
# Jumps with link and odd jalr target
I 000000CC 00C00AEF
I 000000D0 0530A023
I 000000D4 0530A023
I 000000D8 0350AE23
I 000000DC 0F100B13
I 000000E0 000B0BE7
I 000000E4 0530A023
I 000000E8 0530A023
I 000000EC 0530A023
I 000000F0 0570A223
I 000000F4 0040AC03
I 000000F8 0580A423
I 000000FC 0000006F
D 00000380 12345678
S 00000300 00000002
S 00000304 0000000C
S 00000308 00000001
S 0000030C 00000000
S 00000310 F8000100
S 00000314 01000020
S 00000318 00000E00
S 0000031C 000017B3
S 00000320 00000066
S 00000324 00000002
S 00000328 00000007
S 0000032C FFFFFFFB
S 00000330 00000E00
S 00000334 0000000C
S 00000338 F8000100
S 0000033C 000000D0
S 00000344 000000E4
S 00000348 0000000C

// ==== sources.f ====
hdl/rvPkg.sv
hdl/pipeRegister.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/riscvPipeline.sv
test/riscvPipelineAssertions.sv
test/riscvPipelineTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module riscvPipelineTb -Mdir obj_dir
	./obj_dir/VriscvPipelineTb | awk '{ print } $$0 == "PASS: all tests" { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
